/* logic/fpau_cfg.svh */
`ifndef FPAU_CFG_SVH
`define FPAU_CFG_SVH

// single-precision word layout
`define FPAU_DATA_W     32
`define FPAU_EXP_W      8
`define FPAU_MAN_W      23
`define FPAU_EXP_BIAS   127

`define FPAU_U_EXP_MAX  158   // 2^31 still fits unsigned
`define FPAU_S_EXP_MAX  157   // 2^30 is the top signed power

// APB register map
`define FPAU_ADDR_W     5
`define FPAU_REG_OPA    5'h00
`define FPAU_REG_OPB    5'h04
`define FPAU_REG_CTRL   5'h08   // [3:0] opcode, [4] unsigned
`define FPAU_REG_RESULT 5'h0C
`define FPAU_REG_STATUS 5'h10   // [0] done

`endif

/* logic/fpau_pkg.sv */
`include "fpau_cfg.svh"

package fpau_pkg;

	typedef logic [`FPAU_DATA_W-1:0] fp_word_t;

	// codes 0, 1 and 13..15 are unused and give zero
	typedef enum logic [3:0] {
		OP_SGNJ  = 4'd2,
		OP_SGNJN = 4'd3,
		OP_SGNJX = 4'd4,
		OP_MAX   = 4'd5,
		OP_MIN   = 4'd6,
		OP_EQ    = 4'd7,
		OP_LT    = 4'd8,
		OP_LE    = 4'd9,
		OP_MOV   = 4'd10,
		OP_F2I   = 4'd11,
		OP_I2F   = 4'd12
	} fp_op_e;

endpackage

/* logic/fpau_sign_cmp.sv */
`timescale 1ns/1ps
`include "fpau_cfg.svh"

module fpau_sign_cmp import fpau_pkg::*;
(
	input  fp_word_t op_a,
	input  fp_word_t op_b,
	input  fp_op_e   op,
	output fp_word_t cmp_result
);

	localparam int SB = `FPAU_DATA_W - 1;  // sign bit

	logic     sign_a;
	logic     sign_b;
	fp_word_t key_a;
	fp_word_t key_b;
	logic     key_lt;

	assign sign_a = op_a[SB];
	assign sign_b = op_b[SB];

	// ordering key, sign bit flipped
	assign key_a = {~sign_a, op_a[SB-1:0]};
	assign key_b = {~sign_b, op_b[SB-1:0]};
	assign key_lt = key_a < key_b;

	always_comb
	begin
		case (op)
		OP_SGNJ:
			cmp_result = {sign_b, op_a[SB-1:0]};
		OP_SGNJN:
			cmp_result = {~sign_b, op_a[SB-1:0]};
		OP_SGNJX:
			cmp_result = {sign_a ^ sign_b, op_a[SB-1:0]};
		OP_MAX:
			cmp_result = key_lt ? op_b : op_a;
		OP_MIN:
			cmp_result = key_lt ? op_a : op_b;
		// compares work on the raw patterns
		OP_EQ:
			cmp_result = fp_word_t'(op_a == op_b);
		OP_LT:
			cmp_result = fp_word_t'(op_a < op_b);
		OP_LE:
			cmp_result = fp_word_t'(op_a <= op_b);
		OP_MOV:
			cmp_result = op_a;  // bit pattern to integer side
		default:
			cmp_result = '0;
		endcase
	end

endmodule

/* logic/fpau_convert.sv */
`timescale 1ns/1ps
`include "fpau_cfg.svh"

module fpau_convert import fpau_pkg::*;
(
	input  fp_word_t op_a,
	input  fp_op_e   op,
	input  logic     is_unsigned,
	output fp_word_t conv_result
);

	localparam int DW = `FPAU_DATA_W;
	localparam int EW = `FPAU_EXP_W;
	localparam int MW = `FPAU_MAN_W;
	localparam int WIDE_W = DW + MW;       // room for 1.m shifted by up to 31
	localparam int IDX_W = $clog2(DW);

	localparam logic [EW-1:0] BIAS = `FPAU_EXP_BIAS;
	localparam logic [EW-1:0] U_MAX = `FPAU_U_EXP_MAX;
	localparam logic [EW-1:0] S_MAX = `FPAU_S_EXP_MAX;

	logic          a_sign;
	logic [EW-1:0] a_exp;
	logic [MW-1:0] a_man;

	logic              f2i_zero;
	logic [EW-1:0]     f2i_shift;
	logic [WIDE_W-1:0] f2i_wide;
	fp_word_t          f2i_mag;
	fp_word_t          f2i_val;

	logic             i2f_sign;
	fp_word_t         i2f_mag;
	logic [IDX_W-1:0] lead;
	fp_word_t         i2f_norm;
	logic [EW-1:0]    i2f_exp;
	fp_word_t         i2f_val;

	assign a_sign = op_a[DW-1];
	assign a_exp = op_a[DW-2 -: EW];
	assign a_man = op_a[MW-1:0];

	// float to integer, truncating
	always_comb
	begin
		f2i_zero = (a_exp < BIAS)
			|| (is_unsigned && (a_sign || a_exp > U_MAX))
			|| (!is_unsigned && a_exp > S_MAX);
		f2i_shift = a_exp - BIAS;
		f2i_wide = {{(WIDE_W-MW-1){1'b0}}, 1'b1, a_man} << f2i_shift;
		f2i_mag = f2i_wide[WIDE_W-1 -: DW];  // drop the fraction bits
		if (f2i_zero)
			f2i_val = '0;
		else if (!is_unsigned && a_sign)
			f2i_val = -f2i_mag;
		else
			f2i_val = f2i_mag;
	end

	// integer to float, truncating
	always_comb
	begin
		i2f_sign = !is_unsigned && op_a[DW-1];
		i2f_mag = i2f_sign ? -op_a : op_a;
		lead = '0;
		for (int i = 0; i < DW; i++)
		begin
			if (i2f_mag[i])
				lead = IDX_W'(i);  // highest set bit wins
		end
		i2f_norm = i2f_mag << (~lead);  // leading one to bit 31
		i2f_exp = BIAS + {{(EW-IDX_W){1'b0}}, lead};
		if (i2f_mag == '0)
			i2f_val = '0;
		else
			i2f_val = {i2f_sign, i2f_exp, i2f_norm[DW-2 -: MW]};
	end

	always_comb
	begin
		case (op)
		OP_F2I:
			conv_result = f2i_val;
		OP_I2F:
			conv_result = i2f_val;
		default:
			conv_result = '0;
		endcase
	end

endmodule

/* logic/fpau_apb_regs.sv */
`timescale 1ns/1ps
`include "fpau_cfg.svh"

module fpau_apb_regs import fpau_pkg::*;
(
	input  logic                    pclk,
	input  logic                    rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [`FPAU_ADDR_W-1:0] paddr,
	input  fp_word_t                pwdata,
	output fp_word_t                prdata,
	output logic                    pready,
	output logic                    pslverr,
	output fp_word_t                op_a,
	output fp_word_t                op_b,
	output fp_op_e                  op,
	output logic                    is_unsigned,
	input  fp_word_t                cmp_result,
	input  fp_word_t                conv_result
);

	fp_word_t   opa_q;
	fp_word_t   opb_q;
	logic [3:0] op_q;
	logic       uns_q;
	fp_word_t   result_q;
	logic       done_q;

	logic     setup;
	logic     access;
	logic     bad_addr;
	logic     bad_write;
	logic     wr_ok;
	logic     launch;
	fp_word_t rdata;
	fp_word_t unit_result;

	assign setup = psel && !penable;
	assign access = psel && penable;
	assign bad_addr = paddr > `FPAU_REG_STATUS;
	assign bad_write = pwrite && (paddr == `FPAU_REG_RESULT || paddr == `FPAU_REG_STATUS);
	assign wr_ok = access && pwrite && !bad_addr && !bad_write;
	assign launch = wr_ok && paddr == `FPAU_REG_CTRL;

	assign pready = 1'b1;  // no wait states
	assign pslverr = access && (bad_addr || bad_write);

	assign op_a = opa_q;
	assign op_b = opb_q;
	// during a launch the units already see the new opcode
	assign op = fp_op_e'(launch ? pwdata[3:0] : op_q);
	assign is_unsigned = launch ? pwdata[4] : uns_q;

	assign unit_result = (op == OP_F2I || op == OP_I2F) ? conv_result : cmp_result;

	always_comb
	begin
		case (paddr)
		`FPAU_REG_OPA:
			rdata = opa_q;
		`FPAU_REG_OPB:
			rdata = opb_q;
		`FPAU_REG_CTRL:
			rdata = {{(`FPAU_DATA_W-5){1'b0}}, uns_q, op_q};
		`FPAU_REG_RESULT:
			rdata = result_q;
		`FPAU_REG_STATUS:
			rdata = {{(`FPAU_DATA_W-1){1'b0}}, done_q};
		default:
			rdata = '0;
		endcase
	end

	always_ff @(posedge pclk)
	begin
		if (!rst_n)
		begin
			opa_q <= '0;
			opb_q <= '0;
			op_q <= '0;
			uns_q <= 1'b0;
			result_q <= '0;
			done_q <= 1'b0;
			prdata <= '0;
		end
		else
		begin
			if (wr_ok && paddr == `FPAU_REG_OPA)
				opa_q <= pwdata;
			if (wr_ok && paddr == `FPAU_REG_OPB)
				opb_q <= pwdata;
			if (launch)
			begin
				op_q <= pwdata[3:0];
				uns_q <= pwdata[4];
				result_q <= unit_result;
				done_q <= 1'b1;  // result is ready on the same edge
			end
			if (setup)
				prdata <= pwrite ? '0 : rdata;  // valid for the access phase
		end
	end

endmodule

/* logic/fpau_top.sv */
`timescale 1ns/1ps
`include "fpau_cfg.svh"

module fpau_top import fpau_pkg::*;
(
	input  logic                    pclk,
	input  logic                    rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [`FPAU_ADDR_W-1:0] paddr,
	input  fp_word_t                pwdata,
	output fp_word_t                prdata,
	output logic                    pready,
	output logic                    pslverr
);

	fp_word_t op_a;
	fp_word_t op_b;
	fp_op_e   op;
	logic     is_unsigned;
	fp_word_t cmp_result;
	fp_word_t conv_result;

	fpau_apb_regs u_regs (
		.pclk        (pclk),
		.rst_n       (rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.op_a        (op_a),
		.op_b        (op_b),
		.op          (op),
		.is_unsigned (is_unsigned),
		.cmp_result  (cmp_result),
		.conv_result (conv_result)
	);

	fpau_sign_cmp u_sign_cmp (
		.op_a       (op_a),
		.op_b       (op_b),
		.op         (op),
		.cmp_result (cmp_result)
	);

	fpau_convert u_convert (
		.op_a        (op_a),
		.op          (op),
		.is_unsigned (is_unsigned),
		.conv_result (conv_result)
	);

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic pclk,
	output logic rst_n
);

	initial
	begin
		pclk = 1'b0;
		forever #4 pclk = ~pclk;  // 8 ns period
	end

	initial
	begin
		rst_n = 1'b0;
		repeat (2) @(posedge pclk);
		rst_n <= 1'b1;
	end

endmodule

/* tests/fpau_assertions.sv */
`timescale 1ns/1ps
`include "fpau_cfg.svh"

module fpau_assertions import fpau_pkg::*;
(
	input logic                    pclk,
	input logic                    rst_n,
	input logic                    psel,
	input logic                    penable,
	input logic                    pwrite,
	input logic [`FPAU_ADDR_W-1:0] paddr,
	input fp_word_t                prdata,
	input logic                    pready,
	input logic                    pslverr,
	input logic                    done
);

	int unsigned fail_count = 0;  // read by the testbench
	logic        ctrl_write;

	assign ctrl_write = psel && penable && pwrite && paddr == `FPAU_REG_CTRL;

	pready_high: assert property (@(posedge pclk) pready)
	else
	begin
		fail_count++;
		$error("pready went low");
	end

	pslverr_in_access: assert property (@(posedge pclk) pslverr |-> psel && penable)
	else
	begin
		fail_count++;
		$error("pslverr outside an access phase");
	end

	done_after_launch: assert property (@(posedge pclk) disable iff (!rst_n) ctrl_write |=> done)
	else
	begin
		fail_count++;
		$error("done not set after a CTRL write");
	end

	prdata_in_reset: assert property (@(posedge pclk) !rst_n |=> prdata == '0)
	else
	begin
		fail_count++;
		$error("prdata not cleared by reset");
	end

endmodule

bind fpau_apb_regs fpau_assertions u_apb_checks (
	.pclk    (pclk),
	.rst_n   (rst_n),
	.psel    (psel),
	.penable (penable),
	.pwrite  (pwrite),
	.paddr   (paddr),
	.prdata  (prdata),
	.pready  (pready),
	.pslverr (pslverr),
	.done    (done_q)
);

/* tests/fpau_tb.sv */
`timescale 1ns/1ps
`include "fpau_cfg.svh"

module fpau_tb import fpau_pkg::*;
();

	localparam int NUM_RANDOM = 40;
	localparam int TABLE_MAX = 48;
	localparam int CYCLES_PER_VECTOR = 15;  // five transfers of three cycles
	localparam int CYCLE_LIMIT = 2 * (TABLE_MAX + NUM_RANDOM + 12) * CYCLES_PER_VECTOR;

	logic                    pclk;
	logic                    rst_n;
	logic                    psel;
	logic                    penable;
	logic                    pwrite;
	logic [`FPAU_ADDR_W-1:0] paddr;
	fp_word_t                pwdata;
	fp_word_t                prdata;
	logic                    pready;
	logic                    pslverr;

	logic [3:0] tab_op[$];
	logic       tab_uns[$];
	fp_word_t   tab_a[$];
	fp_word_t   tab_b[$];
	fp_word_t   tab_exp[$];
	fp_word_t   lcg_state;
	int         cycle_count = 0;

	tb_clock_gen clk0 (
		.pclk  (pclk),
		.rst_n (rst_n)
	);

	fpau_top dut0 (
		.pclk    (pclk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	task automatic stop_run();
		$display("Some tests failed");
		$fatal(1, "run stopped");
	endtask

	task automatic report_failure(input string msg);
		$display("CHECK FAILED at time %0t: %s", $time, msg);
		stop_run();
	endtask

	always @(posedge pclk)
	begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("ERROR: timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
			stop_run();
		end
	end

	function automatic fp_word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic fp_word_t model_f2i(input fp_word_t a, input logic uns);
		int          e;
		logic [63:0] sig;
		logic [63:0] ival;
		e = int'(a[30:23]) - `FPAU_EXP_BIAS;
		if (e < 0 || (uns && a[31]))
			return '0;
		if ((uns && a[30:23] > `FPAU_U_EXP_MAX) || (!uns && a[30:23] > `FPAU_S_EXP_MAX))
			return '0;
		sig = {40'd0, 1'b1, a[22:0]};
		ival = (e >= 23) ? sig << (e - 23) : sig >> (23 - e);
		if (!uns && a[31])
			ival = -ival;
		return ival[31:0];
	endfunction

	function automatic fp_word_t model_i2f(input fp_word_t a, input logic uns);
		logic     neg;
		fp_word_t mag;
		fp_word_t man;
		int       top;
		neg = !uns && a[31];
		mag = neg ? ~a + 32'd1 : a;
		if (mag == '0)
			return '0;
		top = 31;
		while (!mag[top])
			top--;
		man = (top >= 23) ? mag >> (top - 23) : mag << (23 - top);
		return {neg, 8'(`FPAU_EXP_BIAS + top), man[22:0]};
	endfunction

	function automatic fp_word_t model_result(input logic [3:0] op, input logic uns,
		input fp_word_t a, input fp_word_t b);
		logic key_less;
		key_less = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
		case (op)
		OP_SGNJ:  return {b[31], a[30:0]};
		OP_SGNJN: return {~b[31], a[30:0]};
		OP_SGNJX: return {a[31] ^ b[31], a[30:0]};
		OP_MAX:   return key_less ? b : a;
		OP_MIN:   return key_less ? a : b;
		OP_EQ:    return (a == b) ? 32'd1 : 32'd0;
		OP_LT:    return (a < b) ? 32'd1 : 32'd0;
		OP_LE:    return (a <= b) ? 32'd1 : 32'd0;
		OP_MOV:   return a;
		OP_F2I:   return model_f2i(a, uns);
		OP_I2F:   return model_i2f(a, uns);
		default:  return '0;
		endcase
	endfunction

	task automatic apb_xfer(input logic wr, input logic [`FPAU_ADDR_W-1:0] addr,
		input fp_word_t data, output fp_word_t rdata, output logic err);
		@(posedge pclk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= wr;
		paddr <= addr;
		pwdata <= data;
		@(posedge pclk);
		penable <= 1'b1;
		@(negedge pclk);
		while (!pready)
			@(negedge pclk);
		rdata = prdata;  // mid-cycle, away from the edge
		err = pslverr;
		@(posedge pclk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic write_reg(input logic [`FPAU_ADDR_W-1:0] addr, input fp_word_t data);
		fp_word_t rd;
		logic     err;
		apb_xfer(1'b1, addr, data, rd, err);
		assert (err === 1'b0)
		else report_failure($sformatf("write to 0x%02h raised pslverr", addr));
	endtask

	task automatic read_check(input logic [`FPAU_ADDR_W-1:0] addr, input fp_word_t expected,
		input string what);
		fp_word_t rd;
		logic     err;
		apb_xfer(1'b0, addr, '0, rd, err);
		assert (err === 1'b0)
		else report_failure($sformatf("%s: read of 0x%02h raised pslverr", what, addr));
		assert (rd === expected)
		else report_failure($sformatf("%s: read 0x%08h from 0x%02h, expected 0x%08h",
			what, rd, addr, expected));
	endtask

	task automatic error_check(input logic wr, input logic [`FPAU_ADDR_W-1:0] addr);
		fp_word_t rd;
		logic     err;
		apb_xfer(wr, addr, 32'hFFFF_FFFF, rd, err);
		assert (err === 1'b1)
		else report_failure($sformatf("access to 0x%02h (write %b) gave no pslverr", addr, wr));
	endtask

	task automatic check_protocol();
		if (dut0.u_regs.u_apb_checks.fail_count != 0)
		begin
			$display("ERROR: the APB protocol checker reported a failed assertion");
			stop_run();
		end
	endtask

	task automatic run_vector(input logic [3:0] op, input logic uns, input fp_word_t a,
		input fp_word_t b, input fp_word_t expected, input string what);
		write_reg(`FPAU_REG_OPA, a);
		write_reg(`FPAU_REG_OPB, b);
		write_reg(`FPAU_REG_CTRL, {{(`FPAU_DATA_W-5){1'b0}}, uns, op});  // launch
		read_check(`FPAU_REG_STATUS, 32'd1, {what, " done"});
		read_check(`FPAU_REG_RESULT, expected, what);
		check_protocol();
	endtask

	task automatic add_vector(input logic [3:0] op, input logic uns, input fp_word_t a,
		input fp_word_t b, input fp_word_t expected);
		tab_op.push_back(op);
		tab_uns.push_back(uns);
		tab_a.push_back(a);
		tab_b.push_back(b);
		tab_exp.push_back(expected);
	endtask

	task automatic build_table();
		add_vector(OP_SGNJ,  0, 32'h3F80_0000, 32'hC000_0000, 32'hBF80_0000);
		add_vector(OP_SGNJN, 0, 32'h3F80_0000, 32'hC000_0000, 32'h3F80_0000);
		add_vector(OP_SGNJN, 0, 32'h4049_0FDB, 32'h3F80_0000, 32'hC049_0FDB);
		add_vector(OP_SGNJX, 0, 32'hBF80_0000, 32'hC000_0000, 32'h3F80_0000);
		add_vector(OP_SGNJX, 0, 32'h3F80_0000, 32'hC000_0000, 32'hBF80_0000);
		add_vector(OP_MOV,   0, 32'hDEAD_BEEF, 32'h1234_5678, 32'hDEAD_BEEF);
		add_vector(OP_MAX,   0, 32'h3F80_0000, 32'h4000_0000, 32'h4000_0000);
		add_vector(OP_MIN,   0, 32'h3F80_0000, 32'h4000_0000, 32'h3F80_0000);
		add_vector(OP_MAX,   0, 32'hBF80_0000, 32'h3F80_0000, 32'h3F80_0000);
		add_vector(OP_MIN,   0, 32'hBF80_0000, 32'h3F80_0000, 32'hBF80_0000);
		add_vector(OP_MAX,   0, 32'hC000_0000, 32'hBF80_0000, 32'hC000_0000);  // key order
		add_vector(OP_MIN,   0, 32'h4040_0000, 32'h4040_0000, 32'h4040_0000);
		add_vector(OP_EQ,    0, 32'h4040_0000, 32'h4040_0000, 32'd1);
		add_vector(OP_EQ,    0, 32'h4040_0000, 32'h4040_0001, 32'd0);
		add_vector(OP_LT,    0, 32'h3F80_0000, 32'hBF80_0000, 32'd1);  // raw unsigned
		add_vector(OP_LT,    0, 32'h1234_5678, 32'h1234_5678, 32'd0);
		add_vector(OP_LE,    0, 32'h1234_5678, 32'h1234_5678, 32'd1);
		add_vector(OP_LE,    0, 32'hBF80_0000, 32'h3F80_0000, 32'd0);
		add_vector(OP_F2I,   0, 32'h4070_0000, 32'h0, 32'd3);
		add_vector(OP_F2I,   0, 32'hC070_0000, 32'h0, 32'hFFFF_FFFD);
		add_vector(OP_F2I,   1, 32'hC070_0000, 32'h0, 32'd0);
		add_vector(OP_F2I,   0, 32'h3F00_0000, 32'h0, 32'd0);
		add_vector(OP_F2I,   0, 32'h4F00_0000, 32'h0, 32'd0);  // exponent 158 signed
		add_vector(OP_F2I,   1, 32'h4F00_0000, 32'h0, 32'h8000_0000);
		add_vector(OP_F2I,   1, 32'h4F80_0000, 32'h0, 32'd0);  // exponent 159 unsigned
		add_vector(OP_F2I,   0, 32'h4E80_0000, 32'h0, 32'h4000_0000);
		add_vector(OP_F2I,   0, 32'hCE80_0000, 32'h0, 32'hC000_0000);
		add_vector(OP_I2F,   0, 32'h0000_0001, 32'h0, 32'h3F80_0000);
		add_vector(OP_I2F,   0, 32'hFFFF_FFFF, 32'h0, 32'hBF80_0000);
		add_vector(OP_I2F,   1, 32'h8000_0000, 32'h0, 32'h4F00_0000);
		add_vector(OP_I2F,   0, 32'h8000_0000, 32'h0, 32'hCF00_0000);
		add_vector(OP_I2F,   0, 32'h0000_0000, 32'h0, 32'h0000_0000);
		add_vector(OP_I2F,   1, 32'h01FF_FFFF, 32'h0, 32'h4BFF_FFFF);  // low bit truncated
		add_vector(OP_I2F,   0, 32'hFFFF_FFF6, 32'h0, 32'hC120_0000);
		add_vector(4'd0,     0, 32'h3F80_0000, 32'h4000_0000, 32'd0);
		add_vector(4'd1,     0, 32'h3F80_0000, 32'h4000_0000, 32'd0);
		add_vector(4'd15,    1, 32'h3F80_0000, 32'h4000_0000, 32'd0);
	endtask

	initial
	begin
		fp_word_t   a;
		fp_word_t   b;
		fp_word_t   r;
		logic [3:0] op;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		lcg_state = 32'd83;
		build_table();
		wait (rst_n === 1'b1);

		read_check(`FPAU_REG_OPA, 32'd0, "reset OPA");
		read_check(`FPAU_REG_OPB, 32'd0, "reset OPB");
		read_check(`FPAU_REG_CTRL, 32'd0, "reset CTRL");
		read_check(`FPAU_REG_RESULT, 32'd0, "reset RESULT");
		read_check(`FPAU_REG_STATUS, 32'd0, "reset STATUS");

		error_check(1'b1, `FPAU_REG_RESULT);
		error_check(1'b1, `FPAU_REG_STATUS);
		error_check(1'b0, 5'h14);
		error_check(1'b1, 5'h1C);
		read_check(`FPAU_REG_RESULT, 32'd0, "RESULT after refused write");
		read_check(`FPAU_REG_STATUS, 32'd0, "STATUS after refused write");

		for (int i = 0; i < tab_op.size(); i++)
			run_vector(tab_op[i], tab_uns[i], tab_a[i], tab_b[i], tab_exp[i],
				$sformatf("table entry %0d op %0d", i, tab_op[i]));

		for (int i = 0; i < NUM_RANDOM; i++)
		begin
			r = lcg_next();
			op = 4'(2 + i % 11);  // every used opcode in turn
			a = lcg_next();
			b = lcg_next();
			if (op == OP_F2I)
				a = {a[31], 8'(120 + a[30:23] % 45), a[22:0]};  // around both limits
			else if (op == OP_I2F)
				a = a >> r[28:24];
			else if (r[29:28] == 2'b00)
				b = a;
			run_vector(op, r[31], a, b, model_result(op, r[31], a, b),
				$sformatf("random %0d op %0d", i, op));
		end

		// operand and control registers hold the last launch
		read_check(`FPAU_REG_OPA, a, "OPA readback");
		read_check(`FPAU_REG_OPB, b, "OPB readback");
		read_check(`FPAU_REG_CTRL, {{(`FPAU_DATA_W-5){1'b0}}, r[31], op}, "CTRL readback");

		if (dut0.u_regs.u_apb_checks.fail_count == 0)
		begin
			$display("All tests passed");
			$finish;
		end
		else
		begin
			$display("ERROR: the APB protocol checker reported a failed assertion");
			stop_run();
		end
	end

endmodule

/* files.f */
+incdir+logic
logic/fpau_pkg.sv
logic/fpau_sign_cmp.sv
logic/fpau_convert.sv
logic/fpau_apb_regs.sv
logic/fpau_top.sv
tests/tb_clock_gen.sv
tests/fpau_assertions.sv
tests/fpau_tb.sv

/* Bender.yml */
package:
  name: fpau

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/fpau_pkg.sv
      - logic/fpau_sign_cmp.sv
      - logic/fpau_convert.sv
      - logic/fpau_apb_regs.sv
      - logic/fpau_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_clock_gen.sv
      - tests/fpau_assertions.sv
      - tests/fpau_tb.sv
